// ==== exec_unit.f ====
source/exec_pkg.sv
source/operand_select.sv
source/op_queue.sv
source/seq_multiplier.sv
source/alu_core.sv
source/exec_unit.sv
dv/exec_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the exec_unit testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f exec_unit.f --top-module exec_unit_tb -o exec_unit_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/exec_unit_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: PASS" sim.log; then
    exit 0
fi
exit 1

// ==== dv/exec_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_unit_tb;
    import exec_pkg::*;

    logic      clk;
    logic      arst_n;
    logic      cyc;
    logic      stb;
    exec_req_t req;
    logic      ack;
    logic      rsp_valid;
    exec_rsp_t rsp;
    logic      rsp_ready;
    int        ready_mode;
    exec_req_t req_q[$];
    exec_rsp_t exp_q[$];

    exec_unit #(.width(xlen), .depth(queue_depth)) dut0 (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // 0 holds ready low, 1 holds it high, 2 random
    always @(negedge clk) begin
        if (ready_mode == 2) begin
            rsp_ready = 1'($urandom);
        end else begin
            rsp_ready = (ready_mode == 1);
        end
    end

    task automatic abort_run(string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_val(string name, logic [63:0] actual, logic [63:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("CHECK FAILED at %0t: %s actual %h expected %h",
                                $time, name, actual, expected));
        end
    endtask

    // expected result from the operand select and operation rules
    function automatic exec_rsp_t expect_rsp(exec_req_t r);
        logic [63:0]        a;
        logic [63:0]        b;
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [31:0] lo;
        logic [5:0]         sh;
        exec_rsp_t          e;
        a = (r.sel_a != src_rs1) ? r.pc : (r.word ? {32'h0, r.rs1[31:0]} : r.rs1);
        b = (r.sel_b == src_rs2) ? r.rs2 : ((r.sel_b == src_csr) ? r.csr : r.imm);
        sa = a;
        sb = b;
        lo = a[31:0];
        sh = b[5:0];
        e.op = r.op;
        case (r.op)
            alu_add:   e.result = a + b;
            alu_sub:   e.result = a - b;
            alu_ret_a: e.result = a;
            alu_ret_b: e.result = b;
            alu_xor:   e.result = a ^ b;
            alu_or:    e.result = a | b;
            alu_and:   e.result = a & b;
            alu_sll:   e.result = a << sh;
            alu_srl:   e.result = a >> sh;
            alu_sra: begin
                if (r.word) begin
                    e.result = {32'h0, lo >>> sh};
                end else begin
                    e.result = sa >>> sh;
                end
            end
            alu_slt:   e.result = {63'h0, sa < sb};
            alu_sltu:  e.result = {63'h0, a < b};
            alu_eq:    e.result = {63'h0, a == b};
            alu_ge:    e.result = {63'h0, sa >= sb};
            alu_geu:   e.result = {63'h0, a >= b};
            alu_mul:   e.result = a * b;
            default:   e.result = '0;
        endcase
        return e;
    endfunction

    function automatic exec_req_t rand_req(alu_op_e op, logic word);
        exec_req_t r;
        r.pc    = {$urandom, $urandom};
        r.rs1   = {$urandom, $urandom};
        r.rs2   = {$urandom, $urandom};
        r.csr   = {$urandom, $urandom};
        r.imm   = {$urandom, $urandom};
        r.sel_a = sel_a_e'(2'($urandom));
        r.sel_b = sel_b_e'(2'($urandom));
        r.word  = word;
        r.op    = op;
        return r;
    endfunction

    task automatic drive_req(exec_req_t r);
        @(negedge clk);
        cyc = 1'b1;
        stb = 1'b1;
        req = r;
    endtask

    task automatic bus_idle();
        @(negedge clk);
        cyc = 1'b0;
        stb = 1'b0;
    endtask

    task automatic wait_ack();
        int waited;
        waited = 0;
        @(posedge clk);
        while (!ack) begin
            waited++;
            if (waited > 1000) abort_run("timeout: request was never acknowledged");
            @(posedge clk);
        end
        exp_q.push_back(expect_rsp(req));
    endtask

    task automatic collect(int count);
        exec_rsp_t e;
        int        waited;
        for (int i = 0; i < count; i++) begin
            waited = 0;
            @(posedge clk);
            while (!(rsp_valid && rsp_ready)) begin
                waited++;
                if (waited > 2000) abort_run("timeout: result was never handed over");
                @(posedge clk);
            end
            if (exp_q.size() == 0) abort_run("result arrived with no request outstanding");
            e = exp_q.pop_front();
            check_val("rsp.result", rsp.result, e.result);
            check_val("rsp.op", 64'(rsp.op), 64'(e.op));
        end
    endtask

    // issue everything in req_q back to back while collecting results
    task automatic run_stream();
        int n;
        n = req_q.size();
        fork
            begin
                foreach (req_q[i]) begin
                    drive_req(req_q[i]);
                    wait_ack();
                end
                bus_idle();
            end
            collect(n);
        join
        req_q.delete();
    endtask

    task automatic idle_after_reset();
        repeat (4) begin
            @(posedge clk);
            check_val("ack", 64'(ack), 64'h0);
            check_val("rsp_valid", 64'(rsp_valid), 64'h0);
        end
    endtask

    task automatic single_cycle_ops();
        logic [63:0] fix_a [5];
        logic [63:0] fix_b [5];
        exec_req_t   r;
        // sign mix, equal values, shift by 0 and by 63
        fix_a = '{64'hffff_ffff_ffff_fff0, 64'h7fff_ffff_ffff_ffff, 64'h1234,
                  64'h8000_0000_0000_0001, 64'h8000_0000_8000_0001};
        fix_b = '{64'h10, 64'h8000_0000_0000_0000, 64'h1234, 64'h0, 64'd63};
        ready_mode = 1;
        for (int op = 0; op < 15; op++) begin
            for (int s = 0; s < 16; s++) begin
                for (int k = 0; k < 6; k++) begin
                    r = rand_req(alu_op_e'(5'(op)), 1'b0);
                    r.sel_a = sel_a_e'(2'(s / 4));
                    r.sel_b = sel_b_e'(2'(s));
                    if (k < 5) begin
                        r.pc  = fix_a[k];
                        r.rs1 = fix_a[k];
                        r.rs2 = fix_b[k];
                        r.csr = fix_b[k];
                        r.imm = fix_b[k];
                    end
                    req_q.push_back(r);
                end
            end
        end
        run_stream();
    endtask

    task automatic word_mode_ops();
        exec_req_t r;
        ready_mode = 1;
        for (int op = 0; op < 16; op++) begin
            for (int k = 0; k < 8; k++) begin
                r = rand_req(alu_op_e'(5'(op)), 1'b1);
                r.sel_a = src_rs1;
                if (k == 0) begin
                    // negative low word under junk high bits
                    r.rs1   = 64'h0123_4567_8000_00f0;
                    r.rs2   = 64'd4;
                    r.sel_b = src_rs2;
                end
                req_q.push_back(r);
            end
        end
        run_stream();
    endtask

    task automatic multiply_ops();
        exec_req_t r;
        int        cycles;
        ready_mode = 1;
        for (int k = 0; k < 8; k++) begin
            r = rand_req(alu_mul, 1'b0);
            r.sel_a = src_rs1;
            r.sel_b = src_rs2;
            case (k)
                4: r.rs1 = '0;
                5: r.rs2 = '0;
                6: begin
                    r.rs1 = '1;
                    r.rs2 = '1;
                end
                7: r.rs1 = '1;
                default: ;
            endcase
            req_q.push_back(r);
        end
        run_stream();
        // lone multiply timed from its ack
        ready_mode = 0;
        drive_req(rand_req(alu_mul, 1'b0));
        wait_ack();
        cycles = 0;
        while (!rsp_valid) begin
            @(negedge clk);
            cyc = 1'b0;
            stb = 1'b0;
            @(posedge clk);
            cycles++;
            if (cycles > 200) abort_run("timeout: multiply result never became valid");
        end
        check_val("mul latency at least 64", 64'(cycles >= 64), 64'h1);
        ready_mode = 1;
        collect(1);
    endtask

    task automatic back_pressure();
        ready_mode = 0;
        for (int k = 0; k < 3; k++) begin
            drive_req(rand_req(alu_op_e'(5'(k)), 1'b0));
            wait_ack();
        end
        // one held in the result register and two queued
        drive_req(rand_req(alu_xor, 1'b0));
        repeat (10) begin
            @(posedge clk);
            check_val("ack while full", 64'(ack), 64'h0);
        end
        ready_mode = 1;
        fork
            begin
                wait_ack();
                bus_idle();
            end
            collect(4);
        join
    endtask

    task automatic mixed_stream();
        exec_req_t r;
        ready_mode = 2;
        for (int k = 0; k < 32; k++) begin
            if (k % 4 == 0) begin
                r = rand_req(alu_mul, 1'($urandom));
            end else if (k % 8 == 3) begin
                // div, divu, rem, remu in turn
                r = rand_req(alu_op_e'(5'(16 + (k / 8) % 4)), 1'($urandom));
            end else begin
                r = rand_req(alu_op_e'(5'($urandom_range(19, 0))), 1'($urandom));
            end
            req_q.push_back(r);
        end
        run_stream();
    endtask

    initial begin
        void'($urandom(32'h110b1999));
        arst_n     = 1'b0;
        cyc        = 1'b0;
        stb        = 1'b0;
        req        = '0;
        rsp_ready  = 1'b0;
        ready_mode = 0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        idle_after_reset();
        single_cycle_ops();
        word_mode_ops();
        multiply_ops();
        back_pressure();
        mixed_stream();
        repeat (4) @(posedge clk);
        if (exp_q.size() != 0 || rsp_valid) begin
            abort_run("results still outstanding at the end of the run");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== source/exec_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_unit #(
    parameter int width = exec_pkg::xlen,
    parameter int depth = exec_pkg::queue_depth
) (
    input  logic                 clk,
    input  logic                 arst_n,
    // wishbone request port
    input  logic                 cyc,
    input  logic                 stb,
    input  exec_pkg::exec_req_t  req,
    output logic                 ack,
    // result stream
    output logic                 rsp_valid,
    output exec_pkg::exec_rsp_t  rsp,
    input  logic                 rsp_ready
);
    import exec_pkg::*;

    logic             push;
    exec_op_t         push_op;
    logic             full;
    logic             pop;
    exec_op_t         head;
    logic             not_empty;
    logic             mul_start;
    logic [width-1:0] mul_a;
    logic [width-1:0] mul_b;
    logic             mul_done;
    logic [width-1:0] mul_product;

    operand_select u_select (
        .clk     (clk),
        .arst_n  (arst_n),
        .cyc     (cyc),
        .stb     (stb),
        .req     (req),
        .full    (full),
        .ack     (ack),
        .push    (push),
        .push_op (push_op)
    );

    op_queue #(
        .width (width),
        .depth (depth)
    ) u_queue (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (push),
        .push_op   (push_op),
        .pop       (pop),
        .head      (head),
        .not_empty (not_empty),
        .full      (full)
    );

    alu_core #(
        .width (width)
    ) u_alu (
        .clk         (clk),
        .arst_n      (arst_n),
        .head        (head),
        .not_empty   (not_empty),
        .pop         (pop),
        .mul_start   (mul_start),
        .mul_a       (mul_a),
        .mul_b       (mul_b),
        .mul_done    (mul_done),
        .mul_product (mul_product),
        .rsp_valid   (rsp_valid),
        .rsp         (rsp),
        .rsp_ready   (rsp_ready)
    );

    // busy is only needed inside the multiplier
    seq_multiplier #(
        .width (width)
    ) u_mul (
        .clk     (clk),
        .arst_n  (arst_n),
        .start   (mul_start),
        .a       (mul_a),
        .b       (mul_b),
        .busy    (),
        .done    (mul_done),
        .product (mul_product)
    );

endmodule

`default_nettype wire

// ==== source/alu_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_core #(
    parameter int width = exec_pkg::xlen
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  exec_pkg::exec_op_t   head,
    input  logic                 not_empty,
    output logic                 pop,
    output logic                 mul_start,
    output logic [width-1:0]     mul_a,
    output logic [width-1:0]     mul_b,
    input  logic                 mul_done,
    input  logic [width-1:0]     mul_product,
    output logic                 rsp_valid,
    output exec_pkg::exec_rsp_t  rsp,
    input  logic                 rsp_ready
);
    import exec_pkg::*;

    localparam int sh_w = $clog2(width);

    typedef enum logic [1:0] {
        st_idle,
        st_mul_wait,
        st_hold
    } state_e;

    state_e           state;
    logic             issue;
    logic             issue_mul;
    logic             mul_finish;
    logic [sh_w-1:0]  shamt;
    logic [31:0]      sra_word;
    logic [width-1:0] alu_res;

    // result register is free when empty or being taken this cycle
    assign issue      = not_empty && (state == st_idle || (state == st_hold && rsp_ready));
    assign issue_mul  = issue && (head.op == alu_mul);
    assign mul_finish = (state == st_mul_wait) && mul_done;
    assign pop        = (issue && !issue_mul) || mul_finish;
    assign rsp_valid  = (state == st_hold);

    // head stays put until the product comes back
    assign mul_a = head.a;
    assign mul_b = head.b;

    assign shamt    = head.b[sh_w-1:0];
    assign sra_word = $signed(head.a[31:0]) >>> shamt;

    always_comb begin
        case (head.op)
            alu_add:   alu_res = head.a + head.b;
            alu_sub:   alu_res = head.a - head.b;
            alu_ret_a: alu_res = head.a;
            alu_ret_b: alu_res = head.b;
            alu_xor:   alu_res = head.a ^ head.b;
            alu_or:    alu_res = head.a | head.b;
            alu_and:   alu_res = head.a & head.b;
            alu_sll:   alu_res = head.a << shamt;
            alu_srl:   alu_res = head.a >> shamt;
            alu_sra: begin
                // word sra gives the shifted low word, zero-extended
                if (head.word) begin
                    alu_res = {{(width - 32){1'b0}}, sra_word};
                end else begin
                    alu_res = $signed(head.a) >>> shamt;
                end
            end
            alu_slt:   alu_res = width'($signed(head.a) < $signed(head.b));
            alu_sltu:  alu_res = width'(head.a < head.b);
            alu_eq:    alu_res = width'(head.a == head.b);
            alu_ge:    alu_res = width'($signed(head.a) >= $signed(head.b));
            alu_geu:   alu_res = width'(head.a >= head.b);
            default:   alu_res = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (mul_finish) begin
            rsp.result <= mul_product;
            rsp.op     <= head.op;
        end else if (issue && !issue_mul) begin
            rsp.result <= alu_res;
            rsp.op     <= head.op;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= st_idle;
            mul_start <= 1'b0;
        end else begin
            mul_start <= issue_mul;
            case (state)
                st_idle, st_hold: begin
                    if (issue_mul) begin
                        state <= st_mul_wait;
                    end else if (issue) begin
                        state <= st_hold;
                    end else if (rsp_ready) begin
                        state <= st_idle;
                    end
                end
                st_mul_wait: begin
                    if (mul_done) begin
                        state <= st_hold;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/seq_multiplier.sv ====
`timescale 1ns/1ps
`default_nettype none

module seq_multiplier #(
    parameter int width = exec_pkg::xlen
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             start,
    input  logic [width-1:0] a,
    input  logic [width-1:0] b,
    output logic             busy,
    output logic             done,
    output logic [width-1:0] product
);

    localparam int cnt_w = $clog2(width);

    logic [width-1:0] mcand;
    logic [width-1:0] mplier;
    logic [width-1:0] acc;
    logic [width-1:0] acc_next;
    logic [cnt_w-1:0] count;

    // one partial product per cycle, lsb of multiplier first
    assign acc_next = mplier[0] ? acc + mcand : acc;

    // last iteration, product is the accumulator after this add
    assign done    = busy && (count == cnt_w'(width - 1));
    assign product = acc_next;

    always_ff @(posedge clk) begin
        if (start) begin
            mcand  <= a;
            mplier <= b;
            acc    <= '0;
        end else if (busy) begin
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
            acc    <= acc_next;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy  <= 1'b0;
            count <= '0;
        end else begin
            if (start) begin
                busy  <= 1'b1;
                count <= '0;
            end else if (busy) begin
                count <= count + 1'b1;
                if (done) begin
                    busy <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/op_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module op_queue #(
    parameter int width = exec_pkg::xlen,
    parameter int depth = exec_pkg::queue_depth
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                push,
    input  exec_pkg::exec_op_t  push_op,
    input  logic                pop,
    output exec_pkg::exec_op_t  head,
    output logic                not_empty,
    output logic                full
);
    import exec_pkg::*;

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    logic [width-1:0] mem_a [depth];
    logic [width-1:0] mem_b [depth];
    alu_op_e          mem_op [depth];
    logic             mem_word [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             do_push;
    logic             do_pop;

    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        if (ptr == ptr_w'(depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full      = (count == cnt_w'(depth));
    assign not_empty = (count != '0);
    assign do_push   = push && !full;
    assign do_pop    = pop && not_empty;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem_a[wr_ptr]    <= push_op.a;
            mem_b[wr_ptr]    <= push_op.b;
            mem_op[wr_ptr]   <= push_op.op;
            mem_word[wr_ptr] <= push_op.word;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // simultaneous push and pop leaves the count alone
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head.a    = mem_a[rd_ptr];
    assign head.b    = mem_b[rd_ptr];
    assign head.op   = mem_op[rd_ptr];
    assign head.word = mem_word[rd_ptr];

endmodule

`default_nettype wire

// ==== source/operand_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_select (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 cyc,
    input  logic                 stb,
    input  exec_pkg::exec_req_t  req,
    input  logic                 full,
    output logic                 ack,
    output logic                 push,
    output exec_pkg::exec_op_t   push_op
);
    import exec_pkg::*;

    logic [xlen-1:0] rs1_eff;

    // word mode only narrows rs1
    assign rs1_eff = req.word ? {{(xlen - 32){1'b0}}, req.rs1[31:0]} : req.rs1;

    always_comb begin
        push_op.op   = req.op;
        push_op.word = req.word;

        if (req.sel_a == src_rs1) begin
            push_op.a = rs1_eff;
        end else begin
            push_op.a = req.pc;
        end

        case (req.sel_b)
            src_rs2: begin
                push_op.b = req.rs2;
            end
            src_csr: begin
                push_op.b = req.csr;
            end
            default: begin
                push_op.b = req.imm;
            end
        endcase
    end

    // a valid bus cycle with room is written and acked at once
    assign push = cyc && stb && !full;
    assign ack  = push;

endmodule

`default_nettype wire

// ==== source/exec_pkg.sv ====
`default_nettype none

package exec_pkg;

    // default operand width and queue size
    localparam int xlen = 64;
    localparam int queue_depth = 2;

    // operation codes
    typedef enum logic [4:0] {
        alu_add   = 5'd0,
        alu_sub   = 5'd1,
        alu_ret_a = 5'd2,
        alu_ret_b = 5'd3,
        alu_xor   = 5'd4,
        alu_or    = 5'd5,
        alu_and   = 5'd6,
        alu_sll   = 5'd7,
        alu_srl   = 5'd8,
        alu_sra   = 5'd9,
        alu_slt   = 5'd10,
        alu_sltu  = 5'd11,
        alu_eq    = 5'd12,
        alu_ge    = 5'd13,
        alu_geu   = 5'd14,
        alu_mul   = 5'd15,
        // reserved, no divider in this unit
        alu_div   = 5'd16,
        alu_divu  = 5'd17,
        alu_rem   = 5'd18,
        alu_remu  = 5'd19
    } alu_op_e;

    // first operand, anything but rs1 means pc
    typedef enum logic [1:0] {
        src_pc  = 2'd0,
        src_rs1 = 2'd1
    } sel_a_e;

    // second operand, anything but rs2 or csr means imm
    typedef enum logic [1:0] {
        src_imm = 2'd0,
        src_rs2 = 2'd1,
        src_csr = 2'd2
    } sel_b_e;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] rs1;
        logic [xlen-1:0] rs2;
        logic [xlen-1:0] csr;
        logic [xlen-1:0] imm;
        sel_a_e          sel_a;
        sel_b_e          sel_b;
        logic            word;
        alu_op_e         op;
    } exec_req_t;

    // resolved operands, one queue entry
    typedef struct packed {
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        alu_op_e         op;
        logic            word;
    } exec_op_t;

    typedef struct packed {
        logic [xlen-1:0] result;
        alu_op_e         op;
    } exec_rsp_t;

endpackage

`default_nettype wire
